//--- filelist.f
logic/deser_pkg.sv
logic/channel_router.sv
logic/word_assembler.sv
logic/word_collector.sv
logic/channel_deserializer.sv
tb/clock_gen.sv
tb/deserializer_assertions.sv
tb/tb_channel_deserializer.sv

//--- logic/channel_deserializer.sv
// ==========================================================
// top level of the channelized byte deserializer
// takes a stream of channel-tagged bytes and returns one
// 32-bit word per channel for every four bytes of it
// both sides use a valid/ready handshake
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module channel_deserializer (
    input  logic                                clock,
    input  logic                                reset,

    // tagged byte stream in
    input  logic                                in_valid,
    input  logic [deser_pkg::channel_width-1:0] in_channel,
    input  logic [deser_pkg::byte_width-1:0]    in_byte,
    output logic                                in_ready,

    // assembled words out, tagged with their channel
    output logic                                out_valid,
    output logic [deser_pkg::channel_width-1:0] out_channel,
    output logic [deser_pkg::word_width-1:0]    out_word,
    input  logic                                out_ready
);

    import deser_pkg::*;

    // router to lanes, one byte broadcast with a valid per lane
    logic [channel_count-1:0]                 lane_byte_valid;
    logic [channel_count-1:0]                 lane_byte_ready;
    logic [byte_width-1:0]                    lane_byte;

    // lanes to collector, one word per lane
    logic [channel_count-1:0]                 lane_word_valid;
    logic [channel_count-1:0]                 lane_word_ready;
    logic [channel_count-1:0][word_width-1:0] lane_word;

    channel_router router_inst (
        .in_valid        (in_valid),
        .in_channel      (in_channel),
        .in_byte         (in_byte),
        .in_ready        (in_ready),
        .lane_byte_valid (lane_byte_valid),
        .lane_byte_ready (lane_byte_ready),
        .lane_byte       (lane_byte)
    );

    // one assembler per channel, lane number equals channel number
    for (genvar lane = 0; lane < channel_count; lane++) begin : gen_lane
        word_assembler assembler_inst (
            .clock      (clock),
            .reset      (reset),
            .byte_valid (lane_byte_valid[lane]),
            .byte_data  (lane_byte),
            .byte_ready (lane_byte_ready[lane]),
            .word_valid (lane_word_valid[lane]),
            .word_data  (lane_word[lane]),
            .word_ready (lane_word_ready[lane])
        );
    end

    word_collector collector_inst (
        .clock           (clock),
        .reset           (reset),
        .lane_word_valid (lane_word_valid),
        .lane_word       (lane_word),
        .lane_word_ready (lane_word_ready),
        .out_valid       (out_valid),
        .out_channel     (out_channel),
        .out_word        (out_word),
        .out_ready       (out_ready)
    );

endmodule

`default_nettype wire

//--- logic/channel_router.sv
// ==========================================================
// steers each tagged input byte to the lane of its channel
// purely combinational, so a byte reaches its lane in the
// same cycle and in_ready reflects only that lane's room
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module channel_router (
    // tagged byte stream from outside the design
    input  logic                                in_valid,
    input  logic [deser_pkg::channel_width-1:0] in_channel,
    input  logic [deser_pkg::byte_width-1:0]    in_byte,
    output logic                                in_ready,

    // per-lane handshake towards the word assemblers
    output logic [deser_pkg::channel_count-1:0] lane_byte_valid,
    input  logic [deser_pkg::channel_count-1:0] lane_byte_ready,
    output logic [deser_pkg::byte_width-1:0]    lane_byte
);

    import deser_pkg::*;

    // one-hot form of in_channel, before qualification with in_valid
    logic [channel_count-1:0] channel_select;

    // decode the tag into a one-hot lane select
    always_comb begin
        channel_select = '0;
        for (int lane = 0; lane < channel_count; lane++) begin
            if (in_channel == channel_width'(lane)) begin
                channel_select[lane] = 1'b1;
            end
        end
    end

    // only the addressed lane sees a valid byte
    always_comb begin
        lane_byte_valid = channel_select & {channel_count{in_valid}};
    end

    // the byte itself goes to every lane, and the valid picks
    // which one actually takes it
    always_comb begin
        lane_byte = in_byte;
    end

    // a stalled lane only holds back bytes for its own channel,
    // bytes tagged for other lanes see their own ready here
    always_comb begin
        in_ready = |(channel_select & lane_byte_ready);
    end

endmodule

`default_nettype wire

//--- logic/deser_pkg.sv
// ==========================================================
// shared sizes for the channelized byte deserializer
// import into any module or testbench that needs the byte,
// word or channel widths, so every block agrees on them
// ==========================================================

`default_nettype none

package deser_pkg;

    // one serial input word is a single byte
    localparam int byte_width = 8;

    // bytes gathered into each assembled output word
    localparam int bytes_per_word = 4;

    // the assembled word holds all of its bytes side by side,
    // first byte received in the most significant position
    localparam int word_width = byte_width * bytes_per_word;

    // number of channels on the input stream
    // each channel owns exactly one assembler lane, so this is
    // also the lane count
    localparam int channel_count = 4;

    // width of a channel number on the input and output side
    // channel_count is a power of two, so a channel number
    // wraps cleanly when the arbiter steps past the last lane
    localparam int channel_width = 2;

    // the assembler countdown must reach bytes_per_word itself
    // and not only bytes_per_word - 1, hence the extra bit
    localparam int count_width = 3;

    // the count of bytes still to arrive in an empty lane, at the
    // countdown's own width, for loads and compares in the lanes
    localparam logic [count_width-1:0] count_full = count_width'(bytes_per_word);

endpackage

`default_nettype wire

//--- logic/word_assembler.sv
// ==========================================================
// gathers bytes_per_word bytes into one word, first byte in
// the most significant position; a full word can be taken
// while the first byte of the next one arrives, so a steady
// byte stream never stalls on a lane that is being drained
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module word_assembler (
    input  logic                              clock,
    input  logic                              reset,

    // byte side, from the router
    input  logic                              byte_valid,
    input  logic [deser_pkg::byte_width-1:0]  byte_data,
    output logic                              byte_ready,

    // word side, towards the collector
    output logic                              word_valid,
    output logic [deser_pkg::word_width-1:0]  word_data,
    input  logic                              word_ready
);

    import deser_pkg::*;

    // number of bytes still to arrive before the word is complete
    // zero means the word is full and waits to be taken
    logic [count_width-1:0] count;

    // handshakes that complete on the coming clock edge
    logic byte_take;
    logic word_take;

    // the word is complete exactly when no more bytes are expected
    always_comb begin
        word_valid = (count == '0);
    end

    always_comb begin
        word_take = word_valid && word_ready;
    end

    // room for a byte exists while the word is incomplete, and also
    // in the cycle the full word leaves, because its slot is freed
    // on the same edge that the new byte is stored
    always_comb begin
        byte_ready = (count != '0) || word_take;
    end

    always_comb begin
        byte_take = byte_valid && byte_ready;
    end

    // countdown of bytes still missing
    // taking the word reloads the full count, minus one if the first
    // byte of the next word is accepted in that same cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= count_full;
        end else if (word_take) begin
            if (byte_take) begin
                count <= count_full - count_width'(1);
            end else begin
                count <= count_full;
            end
        end else if (byte_take) begin
            count <= count - count_width'(1);
        end
    end

    // shift register of the bytes received so far
    // each new byte enters at the low end and pushes older bytes up,
    // so after bytes_per_word shifts the first byte sits at the top
    // stale bytes from the previous word are pushed out the top as the
    // new word fills, and word_valid stays low until that has happened
    always_ff @(posedge clock) begin
        if (byte_take) begin
            word_data <= {word_data[word_width-byte_width-1:0], byte_data};
        end
    end

endmodule

`default_nettype wire

//--- logic/word_collector.sv
// ==========================================================
// drains the assembler lanes into one registered output in
// round-robin order; the output stage carries the word and
// the number of the lane, and so the channel, it came from
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module word_collector (
    input  logic                                                      clock,
    input  logic                                                      reset,

    // completed words waiting in the lanes
    input  logic [deser_pkg::channel_count-1:0]                       lane_word_valid,
    input  logic [deser_pkg::channel_count-1:0][deser_pkg::word_width-1:0] lane_word,
    output logic [deser_pkg::channel_count-1:0]                       lane_word_ready,

    // registered output stage
    output logic                                                      out_valid,
    output logic [deser_pkg::channel_width-1:0]                       out_channel,
    output logic [deser_pkg::word_width-1:0]                          out_word,
    input  logic                                                      out_ready
);

    import deser_pkg::*;

    // lane granted most recently, the search starts just after it
    logic [channel_width-1:0] last_grant;

    // result of the round-robin search this cycle
    logic                     grant_found;
    logic [channel_width-1:0] grant_index;

    // the output register can load this cycle when it is empty
    // or when its current word leaves on this same edge
    logic stage_open;

    // a lane is really granted only if the stage can take its word
    logic grant_valid;

    always_comb begin
        stage_open = !out_valid || out_ready;
    end

    // walk the lanes starting one past the last grant
    // the last granted lane itself is checked at the very end, so a lane
    // that just got served waits behind every other waiting lane
    // channel_count is a power of two, so the index wraps by truncation
    always_comb begin
        grant_found = 1'b0;
        grant_index = '0;
        for (int offset = 1; offset <= channel_count; offset++) begin
            logic [channel_width-1:0] candidate;
            candidate = last_grant + channel_width'(offset);
            if (!grant_found && lane_word_valid[candidate]) begin
                grant_found = 1'b1;
                grant_index = candidate;
            end
        end
    end

    always_comb begin
        grant_valid = grant_found && stage_open;
    end

    // at most one lane sees ready, and only the one being granted
    always_comb begin
        lane_word_ready = '0;
        if (grant_valid) begin
            lane_word_ready[grant_index] = 1'b1;
        end
    end

    // control state of the output stage and the arbiter
    // the pointer moves only when a lane is actually served, so a stall
    // on out_ready cannot skip any lane that is waiting
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid  <= 1'b0;
            // start just before lane 0, so lane 0 wins the first search
            last_grant <= channel_width'(channel_count - 1);
        end else begin
            if (stage_open) begin
                out_valid <= grant_found;
            end
            if (grant_valid) begin
                last_grant <= grant_index;
            end
        end
    end

    // word and channel of the granted lane, held until taken
    always_ff @(posedge clock) begin
        if (grant_valid) begin
            out_word    <= lane_word[grant_index];
            out_channel <= grant_index;
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the deserializer testbench with Verilator and runs it
# the run counts as passed only when the pass line is printed
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module tb_channel_deserializer \
    -f filelist.f \
    -o sim_channel_deserializer

# a high error limit lets the testbench report a bound assertion itself
sim_output="$(./obj_dir/sim_channel_deserializer +verilator+error+limit+100 2>&1)" || true
echo "$sim_output"

if grep -qxF "test passed" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

//--- tb/clock_gen.sv
// ==========================================================
// free-running testbench clock with an 8 ns period and a
// synchronous reset held high over the first two cycles
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    // half of the 8 ns period
    localparam time half_period = 4ns;

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // reset covers the rising edges at 4 ns and 12 ns and is released
    // on a falling edge, like every other input of the DUT
    initial begin
        reset = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/deserializer_assertions.sv
// ==========================================================
// protocol checks on the external handshakes of the
// deserializer, bound into every channel_deserializer
// a failed check counts up violation_count for the testbench
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module deserializer_assertions (
    input logic                                clock,
    input logic                                reset,
    input logic                                in_ready,
    input logic                                out_valid,
    input logic [deser_pkg::channel_width-1:0] out_channel,
    input logic [deser_pkg::word_width-1:0]    out_word,
    input logic                                out_ready
);

    // number of failed checks so far, read by the testbench top
    int violation_count = 0;

    // a clock edge in reset leaves the output stage empty
    reset_clears_output: assert property (@(posedge clock) reset |=> !out_valid)
        else begin
            violation_count++;
            $error("out_valid was high in the cycle after a reset edge");
        end

    // in the first cycle after reset nothing is held and every lane has room
    reset_state: assert property (@(posedge clock) $fell(reset) |-> (!out_valid && in_ready))
        else begin
            violation_count++;
            $error("out_valid high or in_ready low in the first cycle after reset");
        end

    // an output word that is not taken stays exactly as it was
    output_held: assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_channel) && $stable(out_word)))
        else begin
            violation_count++;
            $error("output stage changed while out_ready was low");
        end

endmodule

bind channel_deserializer deserializer_assertions protocol_checks (
    .clock       (clock),
    .reset       (reset),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_channel (out_channel),
    .out_word    (out_word),
    .out_ready   (out_ready)
);

`default_nettype wire

//--- tb/tb_channel_deserializer.sv
// ==========================================================
// testbench for the channelized byte deserializer
// sends tagged bytes in four phases and lets assertions
// compare each output word with a per-channel model
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module tb_channel_deserializer;

    import deser_pkg::*;

    localparam int random_seed = 67;
    // the four phases need well under 2000 cycles
    localparam int timeout_cycles = 20000;
    // patterns for out_ready
    localparam int ready_always = 0;
    localparam int ready_random = 1;
    localparam int ready_toggle = 2;

    logic clock;
    logic reset;
    logic in_valid;
    logic [channel_width-1:0] in_channel;
    logic [byte_width-1:0] in_byte;
    logic in_ready;
    logic out_valid;
    logic [channel_width-1:0] out_channel;
    logic [word_width-1:0] out_word;
    logic out_ready;

    // handshakes of the last rising edge, replayed into the model on the falling edge
    logic in_fire;
    logic [channel_width-1:0] fire_channel;
    logic [byte_width-1:0] fire_byte;
    logic out_fire;
    logic [channel_width-1:0] out_fire_channel;

    // model state per channel: bytes of the word being built and words still owed
    logic [word_width-1:0] partial_word [channel_count];
    int partial_count [channel_count];
    logic [word_width-1:0] expected_q [channel_count][$];
    logic [word_width-1:0] head_word [channel_count];
    int head_count [channel_count];
    // words of other channels delivered while this channel had one waiting
    int passed_over [channel_count];
    int worst_wait;

    int bytes_sent [channel_count];
    int out_ready_mode;
    logic full_rate_active;
    int cycle_count = 0;

    clock_gen clock_gen_inst (.clock(clock), .reset(reset));

    channel_deserializer channel_deserializer_inst (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_channel(in_channel), .in_byte(in_byte), .in_ready(in_ready),
        .out_valid(out_valid), .out_channel(out_channel), .out_word(out_word),
        .out_ready(out_ready)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_word_mismatch();
        stop_with_failure($sformatf(
            "mismatch at time %0t: channel %0d gave %h, expected %h (%0d owed)",
            $time, out_channel, out_word, head_word[out_channel], head_count[out_channel]));
    endtask

    // the oldest word owed on a channel is the one that must come out next
    word_order_check: assert property (@(posedge clock) disable iff (reset)
        (out_valid && out_ready) |->
            (head_count[out_channel] != 0 && out_word == head_word[out_channel]))
        else report_word_mismatch();

    full_rate_check: assert property (@(posedge clock) disable iff (reset)
        (full_rate_active && in_valid) |-> in_ready)
        else stop_with_failure("in_ready dropped while channel 0 streamed at full rate");

    fairness_check: assert property (@(posedge clock) disable iff (reset)
        worst_wait <= channel_count)
        else stop_with_failure($sformatf("a waiting channel was passed over %0d times", worst_wait));

    always @(posedge clock) begin
        in_fire <= in_valid && in_ready && !reset;
        fire_channel <= in_channel;
        fire_byte <= in_byte;
        out_fire <= out_valid && out_ready && !reset;
        out_fire_channel <= out_channel;
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure("timeout, the output queues did not drain in time");
        end
    end

    // outputs are applied before inputs, so a word finished on the same edge
    // as another channel's output starts waiting with a clean count
    always @(negedge clock) begin : model_update
        int lane;
        if (reset) begin
            for (int ch = 0; ch < channel_count; ch++) begin
                partial_count[ch] = 0;
                passed_over[ch] = 0;
                expected_q[ch].delete();
            end
        end else begin
            if (out_fire) begin
                for (int ch = 0; ch < channel_count; ch++) begin
                    if (ch == int'(out_fire_channel)) begin
                        passed_over[ch] = 0;
                    end else if (expected_q[ch].size() != 0) begin
                        passed_over[ch]++;
                    end
                end
                if (expected_q[out_fire_channel].size() != 0) begin
                    void'(expected_q[out_fire_channel].pop_front());
                end
            end
            if (in_fire) begin
                lane = int'(fire_channel);
                // the first byte of a word lands in the top byte position
                partial_word[lane][byte_width*(bytes_per_word-1-partial_count[lane]) +: byte_width]
                    = fire_byte;
                partial_count[lane]++;
                if (partial_count[lane] == bytes_per_word) begin
                    if (expected_q[lane].size() == 0) begin
                        passed_over[lane] = 0;
                    end
                    expected_q[lane].push_back(partial_word[lane]);
                    partial_count[lane] = 0;
                end
            end
            if (channel_deserializer_inst.protocol_checks.violation_count != 0) begin
                stop_with_failure("a bound protocol assertion failed on the DUT ports");
            end
        end
        worst_wait = 0;
        for (int ch = 0; ch < channel_count; ch++) begin
            head_count[ch] = expected_q[ch].size();
            head_word[ch] = (head_count[ch] != 0) ? expected_q[ch][0] : '0;
            if (passed_over[ch] > worst_wait) begin
                worst_wait = passed_over[ch];
            end
        end
    end

    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clock);
            case (out_ready_mode)
                ready_random: out_ready = ($urandom_range(0, 1) == 1);
                ready_toggle: out_ready = !out_ready;
                default: out_ready = 1'b1;
            endcase
        end
    end

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_byte(input int channel, input logic [byte_width-1:0] value);
        in_valid = 1'b1;
        in_channel = channel_width'(channel);
        in_byte = value;
        bytes_sent[channel]++;
        do begin
            @(negedge clock);
        end while (!in_fire);
        in_valid = 1'b0;
    endtask

    task automatic send_random_bytes(input int total, input bit with_gaps);
        for (int n = 0; n < total; n++) begin
            if (with_gaps) begin
                repeat ($urandom_range(0, 2)) @(negedge clock);
            end
            send_byte($urandom_range(0, channel_count - 1), byte_width'($urandom));
        end
    endtask

    task automatic complete_partial_words();
        for (int ch = 0; ch < channel_count; ch++) begin
            while (bytes_sent[ch] % bytes_per_word != 0) begin
                send_byte(ch, byte_width'($urandom));
            end
        end
    endtask

    // the queues are read on the rising edge, where the model's view from the
    // falling edge before has settled, and the task returns on a falling edge
    task automatic wait_for_drain();
        int pending;
        do begin
            @(posedge clock);
            pending = 0;
            for (int ch = 0; ch < channel_count; ch++) begin
                pending += head_count[ch];
            end
        end while (pending != 0);
        @(negedge clock);
    endtask

    initial begin
        void'($urandom(random_seed));
        in_valid = 1'b0;
        in_channel = '0;
        in_byte = '0;
        out_ready_mode = ready_always;
        full_rate_active = 1'b0;
        for (int ch = 0; ch < channel_count; ch++) begin
            bytes_sent[ch] = 0;
        end
        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end

        // interleaved channels with gaps on the input and a free output
        send_random_bytes(128, 1'b1);
        complete_partial_words();
        wait_for_drain();

        // random stalls on out_ready make the lanes fill and hold
        out_ready_mode = ready_random;
        send_random_bytes(128, 1'b1);
        complete_partial_words();
        wait_for_drain();

        // back to back bytes on channel 0, one word per four cycles leaves
        out_ready_mode = ready_always;
        @(negedge clock);
        full_rate_active = 1'b1;
        for (int n = 0; n < 64; n++) begin
            send_byte(0, byte_width'($urandom));
        end
        full_rate_active = 1'b0;
        wait_for_drain();

        // every channel loaded at once behind a toggling out_ready
        out_ready_mode = ready_toggle;
        send_random_bytes(96, 1'b0);
        complete_partial_words();
        wait_for_drain();

        if (channel_deserializer_inst.protocol_checks.violation_count != 0) begin
            stop_with_failure("a bound protocol assertion failed on the DUT ports");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
